/* all.f */
rtl/bg_pkg.sv
rtl/bg_scan_counter.sv
rtl/bg_reg_decoder.sv
rtl/bg_coord_unit.sv
rtl/bg_fetch_unit.sv
rtl/bg_pixel_formatter.sv
rtl/bg_processing_circuit.sv
verif/bg_clock_gen.sv
verif/bg_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the background pipeline testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module bg_tb -f all.f -o bg_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/bg_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit $sim_status
fi

exit 0

/* verif/bg_tb.sv */
`timescale 1ns/1ps

module bg_tb;
  import bg_pkg::*;

  localparam int LINE_SLOTS    = 308;
  localparam int FRAME_LINES   = 228;
  localparam int VISIBLE_COLS  = 240;
  localparam int VISIBLE_LINES = 160;
  localparam int NUM_TESTS     = 6;
  localparam int WAIT_LIMIT    = 3000;

  typedef struct packed {
    logic [15:0]      dispcnt;
    logic [15:0]      mosaic;
    logic [3:0][15:0] bgcnt;
    logic [3:0][15:0] hofs;
    logic [3:0][15:0] vofs;
    logic [1:0][27:0] ref_x;  // [0] = bg2, [1] = bg3
    logic [1:0][27:0] ref_y;
    logic [1:0][15:0] pa;
    logic [1:0][15:0] pb;
    logic [1:0][15:0] pc;
    logic [1:0][15:0] pd;
    logic [3:0]       lines;
  } test_row_t;

  typedef struct packed {
    logic [2:0]  test;
    logic [15:0] saddr;
    logic [16:0] caddr;
    bg_pixel_t   pix;
    logic        en;
    logic [7:0]  col;
  } expect_t;

  logic             clock;
  logic             rst_n;
  logic [3:0][15:0] bgcnt;
  logic [3:0][15:0] hofs;
  logic [3:0][15:0] vofs;
  logic [27:0]      bg2x, bg3x, bg2y, bg3y;
  logic [15:0]      bg2pa, bg2pb, bg2pc, bg2pd;
  logic [15:0]      bg3pa, bg3pb, bg3pc, bg3pd;
  logic [15:0]      dispcnt;
  logic [15:0]      mosaic;
  logic [15:0]      bg_screen_data = '0;
  logic [15:0]      bg_VRAM_data = '0;
  logic [15:0]      bg_screen_addr;
  logic [16:0]      bg_addr;
  bg_pixel_t        bg_packet;
  logic [7:0]       hcount;
  logic [2:0]       bgmode;

  logic [15:0]      screen_mem [0:65535];
  logic [15:0]      char_mem [0:131071];
  test_row_t        table_rows [NUM_TESTS];
  string            names [NUM_TESTS];
  int               cur_test;
  int               errors;
  integer           seed;

  // reference scan position and affine state
  logic [8:0]       m_col;
  logic [1:0]       m_bgno;
  logic [7:0]       m_row;
  logic             m_frame_start;
  logic [1:0][27:0] m_line_x, m_line_y, m_cur_x, m_cur_y;
  expect_t          pipe [1:3];
  logic [3:1]       pipe_v;

  bg_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(3)) u_clk (.clock, .rst_n);

  bg_processing_circuit #(
    .LINE_SLOTS   (LINE_SLOTS),
    .FRAME_LINES  (FRAME_LINES),
    .VISIBLE_COLS (VISIBLE_COLS),
    .VISIBLE_LINES(VISIBLE_LINES)
  ) DUT (
    .bgcnt, .hofs, .vofs, .bg2x, .bg3x, .bg2y, .bg3y,
    .bg2pa, .bg2pb, .bg2pc, .bg2pd, .bg3pa, .bg3pb, .bg3pc, .bg3pd,
    .dispcnt, .mosaic, .clock, .rst_n, .bg_screen_data, .bg_VRAM_data,
    .bg_screen_addr, .bg_addr, .bg_packet, .hcount, .bgmode
  );

  // video memory, one clock read latency per port
  always @(posedge clock) begin
    bg_screen_data <= screen_mem[bg_screen_addr];
    bg_VRAM_data   <= char_mem[bg_addr];
  end

  function automatic logic [27:0] sign_extend(input logic [15:0] v);
    return {{12{v[15]}}, v};
  endfunction

  function automatic test_row_t make_row(input logic [15:0] dc, input logic [15:0] mos,
                                         input logic [63:0] cnt, input logic [63:0] ho,
                                         input logic [63:0] vo, input logic [3:0] lines);
    test_row_t r;
    r         = '0;
    r.dispcnt = dc;
    r.mosaic  = mos;
    r.bgcnt   = cnt;
    r.hofs    = ho;
    r.vofs    = vo;
    r.pa      = {16'h0100, 16'h0100};  // identity step
    r.pd      = {16'h0100, 16'h0100};
    r.lines   = lines;
    return r;
  endfunction

  task automatic load_table();
    names[0]      = "affine_bg2";
    table_rows[0] = make_row(16'h0C02, 16'h0000, {16'h3008, 16'h4806, 16'h0, 16'h0},
                             64'd0, 64'd0, 4'd2);
    table_rows[0].ref_x = {28'hFFFF000, 28'h0000800};
    table_rows[0].ref_y = {28'h0002000, 28'h0000400};
    table_rows[0].pa    = {16'h0180, 16'h00C0};
    table_rows[0].pb    = {16'h0000, 16'h0010};
    table_rows[0].pc    = {16'h0040, 16'hFFE0};  // bg2 y walks below zero
    names[1]      = "text_scroll";
    table_rows[1] = make_row(16'h0F00, 16'h0000, {16'hD483, 16'h8C02, 16'h4401, 16'h0000},
                             {16'd511, 16'd300, 16'd100, 16'd0},
                             {16'd400, 16'd250, 16'd200, 16'd0}, 4'd2);
    names[2]      = "char_flip";
    table_rows[2] = make_row(16'h0300, 16'h0000, {16'h0, 16'h0, 16'h028D, 16'h010C},
                             {16'd0, 16'd0, 16'd13, 16'd7}, {16'd0, 16'd0, 16'd5, 16'd3}, 4'd1);
    names[3]      = "mosaic";
    table_rows[3] = make_row(16'h0F01, 16'h0032, {16'h0000, 16'h6140, 16'h0000, 16'h0544},
                             {16'd0, 16'd0, 16'd0, 16'd37}, {16'd0, 16'd0, 16'd0, 16'd11}, 4'd2);
    names[4]      = "disabled_layers";
    table_rows[4] = make_row(16'h0500, 16'h0000, {16'h0003, 16'h0002, 16'h0001, 16'h0000},
                             64'd0, 64'd0, 4'd1);
    names[5]      = "bitmap_mode";
    table_rows[5] = make_row(16'h0F03, 16'h0000, {16'h0003, 16'h0002, 16'h0001, 16'h0000},
                             64'd0, 64'd0, 4'd1);
  endtask

  task automatic apply_row(input int t);
    test_row_t r;
    r = table_rows[t];
    dispcnt <= r.dispcnt;
    mosaic  <= r.mosaic;
    bgcnt   <= r.bgcnt;
    hofs    <= r.hofs;
    vofs    <= r.vofs;
    bg2x    <= r.ref_x[0];
    bg3x    <= r.ref_x[1];
    bg2y    <= r.ref_y[0];
    bg3y    <= r.ref_y[1];
    bg2pa   <= r.pa[0];
    bg3pa   <= r.pa[1];
    bg2pb   <= r.pb[0];
    bg3pb   <= r.pb[1];
    bg2pc   <= r.pc[0];
    bg3pc   <= r.pc[1];
    bg2pd   <= r.pd[0];
    bg3pd   <= r.pd[1];
  endtask

  task automatic fail_run();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input int t, input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    assert (exp_v == act_v) else begin
      errors++;
      $display("FAILED %s: %s expected %0h actual %0h", names[t], what, exp_v, act_v);
      fail_run();
    end
  endtask

  // expected addresses and packet for the slot the DUT takes at the next edge
  task automatic predict_slot(output expect_t e);
    logic [15:0] cnt;
    logic [2:0]  mode;
    logic        mode_ok, rotate, pal, outside;
    logic [9:0]  hmax, vmax, x, y;
    logic [27:0] px, py;
    logic [15:0] entry, word;
    logic [7:0]  pix_byte;
    logic [3:0]  bank, nib;
    int          k, tile_n, blocks, fx, fy;
    cnt     = bgcnt[m_bgno];
    mode    = dispcnt[2:0];
    mode_ok = (mode == 3'd0) || (mode == 3'd1 && m_bgno != 2'd3) || (mode == 3'd2 && m_bgno[1]);
    rotate  = (mode == 3'd1 && m_bgno == 2'd2) || (mode == 3'd2 && m_bgno[1]);
    pal     = cnt[7] || rotate;
    e       = '0;
    e.test  = 3'(cur_test);
    e.en    = dispcnt[8 + m_bgno] && mode_ok;
    if (rotate) begin
      hmax = 10'((128 << cnt[15:14]) - 1);
      vmax = hmax;
    end else begin
      hmax = cnt[14] ? 10'd511 : 10'd255;
      vmax = cnt[15] ? 10'd511 : 10'd255;
    end

    px = '0;
    py = '0;
    if (m_bgno[1]) begin
      k = int'(m_bgno[0]);
      if (m_col == 9'd0) begin
        px = m_frame_start ? (k == 1 ? bg3x : bg2x) : m_line_x[k];
        py = m_frame_start ? (k == 1 ? bg3y : bg2y) : m_line_y[k];
        m_line_x[k] = px;
        m_line_y[k] = py;
      end else begin
        px = m_cur_x[k];
        py = m_cur_y[k];
      end
      m_cur_x[k] = px + sign_extend(k == 1 ? bg3pa : bg2pa);
      m_cur_y[k] = py + sign_extend(k == 1 ? bg3pc : bg2pc);
    end
    outside = px[27] || py[27] || (px[26:8] > 19'(hmax)) || (py[26:8] > 19'(vmax));
    if (rotate) begin
      x = px[17:8] & hmax;
      y = py[17:8] & vmax;
    end else begin
      x = 10'(int'(m_col) + int'(hofs[m_bgno][8:0])) & hmax;
      y = 10'(int'(m_row) + int'(vofs[m_bgno][8:0])) & vmax;
    end
    if (cnt[6] && mosaic[7:0] != 8'd0) begin
      x = 10'((int'(x) / (int'(mosaic[3:0]) + 1)) * (int'(mosaic[3:0]) + 1));
      y = 10'((int'(y) / (int'(mosaic[7:4]) + 1)) * (int'(mosaic[7:4]) + 1));
    end

    if (rotate) begin
      tile_n  = (int'(y) / 8) * ((int'(hmax) + 1) / 8) + int'(x) / 8;
      e.saddr = 16'(int'(cnt[12:8]) * 1024 + tile_n / 2);
    end else begin
      blocks = (x >= 10'd256) ? 1 : 0;
      if (y >= 10'd256) begin
        blocks += (hmax == 10'd511) ? 2 : 1;
      end
      e.saddr = 16'(int'(cnt[12:8]) * 1024 + blocks * 1024 + ((int'(y) / 8) % 32) * 32
                    + (int'(x) / 8) % 32);
    end

    entry = screen_mem[e.saddr];
    if (rotate) begin
      tile_n = (tile_n % 2 == 1) ? int'(entry[15:8]) : int'(entry[7:0]);
      fx     = int'(x) % 8;
      fy     = int'(y) % 8;
      bank   = 4'd0;
    end else begin
      tile_n = int'(entry[9:0]);
      fx     = entry[10] ? 7 - int'(x) % 8 : int'(x) % 8;
      fy     = entry[11] ? 7 - int'(y) % 8 : int'(y) % 8;
      bank   = entry[15:12];
    end
    if (pal) begin
      e.caddr = 17'(int'(cnt[3:2]) * 8192 + tile_n * 32 + fy * 4 + fx / 2);
    end else begin
      e.caddr = 17'(int'(cnt[3:2]) * 8192 + tile_n * 16 + fy * 2 + fx / 4);
    end

    word     = char_mem[e.caddr];
    pix_byte = (fx % 2 == 1) ? word[15:8] : word[7:0];
    nib      = word[(fx % 4) * 4 +: 4];
    e.pix.used        = e.en && (m_col < 9'(VISIBLE_COLS)) && (m_row < 8'(VISIBLE_LINES));
    e.pix.bg_priority = cnt[1:0];
    e.pix.bgno        = m_bgno;
    e.pix.palettemode = pal;
    e.pix.color_index = pal ? pix_byte : {bank, nib};
    e.pix.transparent = (rotate && !cnt[13] && outside) || (pal ? pix_byte == 8'd0 : nib == 4'd0);
    e.col      = m_col[7:0];
  endtask

  task automatic advance_slot();
    if (m_col == 9'(LINE_SLOTS - 1) && m_bgno == 2'd3) begin
      m_line_x[0]   = m_line_x[0] + sign_extend(bg2pb);
      m_line_y[0]   = m_line_y[0] + sign_extend(bg2pd);
      m_line_x[1]   = m_line_x[1] + sign_extend(bg3pb);
      m_line_y[1]   = m_line_y[1] + sign_extend(bg3pd);
      m_frame_start = (m_row == 8'(FRAME_LINES - 1));
      m_row         = m_frame_start ? 8'd0 : m_row + 8'd1;
      m_col         = 9'd0;
      m_bgno        = 2'd0;
    end else begin
      {m_col, m_bgno} = {m_col, m_bgno} + 11'd1;
    end
  endtask

  always @(negedge clock) begin
    if (!rst_n) begin
      check_value(cur_test, "reset used", 32'd0, 32'(bg_packet.used));
      check_value(cur_test, "reset screen addr", 32'd0, 32'(bg_screen_addr));
      check_value(cur_test, "reset char addr", 32'd0, 32'(bg_addr));
    end else begin
      check_value(cur_test, "bgmode", 32'(table_rows[cur_test].dispcnt[2:0]), 32'(bgmode));
      if (pipe_v[1]) begin
        check_value(int'(pipe[1].test), "screen addr", 32'(pipe[1].saddr), 32'(bg_screen_addr));
      end else begin
        check_value(cur_test, "idle screen addr", 32'd0, 32'(bg_screen_addr));
      end
      if (!pipe_v[2]) begin
        check_value(cur_test, "idle char addr", 32'd0, 32'(bg_addr));
      end else if (pipe[2].en) begin
        check_value(int'(pipe[2].test), "char addr", 32'(pipe[2].caddr), 32'(bg_addr));
      end
      if (!pipe_v[3]) begin
        check_value(cur_test, "idle used", 32'd0, 32'(bg_packet.used));
      end else begin
        check_value(int'(pipe[3].test), "hcount", 32'(pipe[3].col), 32'(hcount));
        if (pipe[3].en) begin
          check_value(int'(pipe[3].test), "packet", 32'(pipe[3].pix[12:0]),
                      32'(bg_packet[12:0]));
        end
        check_value(int'(pipe[3].test), "used", 32'(pipe[3].pix.used), 32'(bg_packet.used));
      end
      pipe[3] = pipe[2];
      pipe[2] = pipe[1];
      predict_slot(pipe[1]);
      pipe_v = {pipe_v[2:1], 1'b1};
      advance_slot();
    end
  end

  task automatic wait_reset_release();
    int n;
    n = 0;
    do begin
      @(negedge clock);
      n++;
      if (n > 10) begin
        $display("reset was never released");
        fail_run();
      end
    end while (!rst_n);
  endtask

  // returns on the edge that takes the next-to-last slot of a line
  task automatic wait_line_end();
    int n;
    n = 0;
    do begin
      @(posedge clock);
      n++;
      if (n > WAIT_LIMIT) begin
        $display("no line end within %0d clocks", WAIT_LIMIT);
        fail_run();
      end
    end while (!(m_col == 9'(LINE_SLOTS - 1) && m_bgno == 2'd3));
  endtask

  initial begin
    seed          = 95;
    errors        = 0;
    cur_test      = 0;
    m_col         = '0;
    m_bgno        = '0;
    m_row         = '0;
    m_frame_start = 1'b1;
    m_line_x      = '0;
    m_line_y      = '0;
    m_cur_x       = '0;
    m_cur_y       = '0;
    pipe_v        = '0;
    for (int i = 0; i < 65536; i++) begin
      screen_mem[i] = 16'($random(seed));
    end
    for (int i = 0; i < 131072; i++) begin
      char_mem[i] = 16'($random(seed));
    end
    load_table();
    apply_row(0);  // first row sits in place before the first frame starts
    wait_reset_release();
    for (int t = 0; t < NUM_TESTS; t++) begin
      if (t > 0) begin
        cur_test = t;
        apply_row(t);
      end
      repeat (int'(table_rows[t].lines)) wait_line_end();
    end
    repeat (8) @(posedge clock);
    if (errors == 0) begin
      $display("test passed");
      $finish;
    end else begin
      fail_run();
    end
  end

endmodule

/* verif/bg_clock_gen.sv */
`timescale 1ns/1ps

module bg_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 3
) (
  output logic clock,
  output logic rst_n
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD_NS / 2) clock = ~clock;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #(PERIOD_NS / 4) rst_n = 1'b1;  // away from both edges
  end

endmodule

/* rtl/bg_processing_circuit.sv */
`timescale 1ns/1ps

module bg_processing_circuit #(
  parameter int LINE_SLOTS    = 308,
  parameter int FRAME_LINES   = 228,
  parameter int VISIBLE_COLS  = 240,
  parameter int VISIBLE_LINES = 160
) (
  input  logic [3:0][15:0]  bgcnt,
  input  logic [3:0][15:0]  hofs,
  input  logic [3:0][15:0]  vofs,
  input  logic [27:0]       bg2x,
  input  logic [27:0]       bg3x,
  input  logic [27:0]       bg2y,
  input  logic [27:0]       bg3y,
  input  logic [15:0]       bg2pa,
  input  logic [15:0]       bg2pb,
  input  logic [15:0]       bg2pc,
  input  logic [15:0]       bg2pd,
  input  logic [15:0]       bg3pa,
  input  logic [15:0]       bg3pb,
  input  logic [15:0]       bg3pc,
  input  logic [15:0]       bg3pd,
  input  logic [15:0]       dispcnt,
  input  logic [15:0]       mosaic,          // h size [3:0], v size [7:4]
  input  logic              clock,
  input  logic              rst_n,
  input  logic [15:0]       bg_screen_data,
  input  logic [15:0]       bg_VRAM_data,
  output logic [15:0]       bg_screen_addr,
  output logic [16:0]       bg_addr,
  output bg_pkg::bg_pixel_t bg_packet,
  output logic [7:0]        hcount,          // column for the object renderer
  output logic [2:0]        bgmode
);
  import bg_pkg::*;

  bg_slot_t    slot;
  logic        start_row;
  logic        new_frame;
  bg_layer_t   layer;
  bg_coord_t   coord;
  bg_coord_t   stage;
  logic [3:0]  palette_bank;
  logic [1:0]  vis_pipe;

  assign bgmode = dispcnt[2:0];

  bg_scan_counter #(
    .LINE_SLOTS   (LINE_SLOTS),
    .FRAME_LINES  (FRAME_LINES),
    .VISIBLE_COLS (VISIBLE_COLS),
    .VISIBLE_LINES(VISIBLE_LINES)
  ) u_scan (
    .clock, .rst_n, .slot, .start_row, .new_frame
  );

  bg_reg_decoder u_decode (
    .bgcnt, .hofs, .vofs,
    .bg2x, .bg3x, .bg2y, .bg3y,
    .bg2pa, .bg2pc, .bg3pa, .bg3pc,
    .dispcnt, .mosaic_reg(mosaic), .bgno(slot.bgno),
    .layer
  );

  bg_coord_unit u_coord (
    .clock, .rst_n, .layer, .slot, .start_row, .new_frame,
    .mosaic_reg(mosaic), .bg2pb, .bg2pd, .bg3pb, .bg3pd,
    .coord, .bg_screen_addr
  );

  bg_fetch_unit u_fetch (
    .clock, .rst_n, .coord, .bg_screen_data, .bg_addr, .stage, .palette_bank
  );

  // visible rides two stages to meet the formatter
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      vis_pipe <= '0;
    end else begin
      vis_pipe <= {vis_pipe[0], slot.visible};
    end
  end

  bg_pixel_formatter u_format (
    .clock, .rst_n, .stage, .palette_bank, .bg_VRAM_data,
    .visible_d(vis_pipe[1]), .pixel(bg_packet), .hcount
  );

endmodule

/* rtl/bg_pixel_formatter.sv */
`timescale 1ns/1ps

module bg_pixel_formatter (
  input  logic              clock,
  input  logic              rst_n,
  input  bg_pkg::bg_coord_t stage,
  input  logic [3:0]        palette_bank,
  input  logic [15:0]       bg_VRAM_data,
  input  logic              visible_d,
  output bg_pkg::bg_pixel_t pixel,
  output logic [7:0]        hcount
);
  import bg_pkg::*;

  bg_coord_t  fmt_q;
  logic [3:0] bank_q;
  logic       vis_q;
  logic [3:0] nib;
  logic [7:0] pix_byte;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      fmt_q  <= '0;
      bank_q <= '0;
      vis_q  <= 1'b0;
    end else begin
      fmt_q  <= stage;
      bank_q <= palette_bank;
      vis_q  <= visible_d;
    end
  end

  // char data lands on the same edge, so selection stays combinational
  always_comb begin
    nib      = bg_VRAM_data[{fmt_q.x[1:0], 2'b00} +: 4];
    pix_byte = fmt_q.x[0] ? bg_VRAM_data[15:8] : bg_VRAM_data[7:0];

    pixel.used        = fmt_q.enabled && vis_q;
    pixel.bg_priority = fmt_q.bg_priority;
    pixel.bgno        = fmt_q.bgno;
    pixel.palettemode = fmt_q.palettemode;
    if (fmt_q.palettemode) begin
      pixel.color_index = pix_byte;
      pixel.transparent = fmt_q.transparent || (pix_byte == 8'd0);
    end else begin
      pixel.color_index = {bank_q, nib};
      pixel.transparent = fmt_q.transparent || (nib == 4'd0);  // colour 0 is see-through
    end
  end

  assign hcount = fmt_q.col[7:0];

endmodule

/* rtl/bg_fetch_unit.sv */
`timescale 1ns/1ps

module bg_fetch_unit (
  input  logic              clock,
  input  logic              rst_n,
  input  bg_pkg::bg_coord_t coord,
  input  logic [15:0]       bg_screen_data,
  output logic [16:0]       bg_addr,
  output bg_pkg::bg_coord_t stage,
  output logic [3:0]        palette_bank
);
  import bg_pkg::*;

  bg_coord_t   stage_q;
  logic [15:0] entry;
  logic [9:0]  tile;
  logic [2:0]  fx, fy;   // in-tile position after flips
  logic [16:0] offs;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      stage_q <= '0;
    end else begin
      stage_q <= coord;
    end
  end

  always_comb begin
    entry = stage_q.enabled ? bg_screen_data : 16'd0;  // disabled layers fetch tile 0
    if (stage_q.rotate) begin
      // one tile byte per map entry, x[3] picks the byte
      tile         = {2'b00, stage_q.x[3] ? entry[15:8] : entry[7:0]};
      fx           = stage_q.x[2:0];
      fy           = stage_q.y[2:0];
      palette_bank = 4'd0;
    end else begin
      tile         = entry[9:0];
      fx           = stage_q.x[2:0] ^ {3{entry[10]}};  // hflip
      fy           = stage_q.y[2:0] ^ {3{entry[11]}};  // vflip
      palette_bank = entry[15:12];
    end

    if (stage_q.palettemode) begin
      offs = {2'b00, tile, fy, fx[2:1]};  // 32 halfwords per tile
    end else begin
      offs = {3'b000, tile, fy, fx[2]};   // 16 halfwords per tile
    end
    bg_addr = {2'b00, stage_q.char_base, 13'd0} + offs;

    stage        = stage_q;
    stage.x[2:0] = fx;
  end

endmodule

/* rtl/bg_coord_unit.sv */
`timescale 1ns/1ps

module bg_coord_unit (
  input  logic              clock,
  input  logic              rst_n,
  input  bg_pkg::bg_layer_t layer,
  input  bg_pkg::bg_slot_t  slot,
  input  logic              start_row,
  input  logic              new_frame,
  input  logic [15:0]       mosaic_reg,
  input  logic [15:0]       bg2pb,
  input  logic [15:0]       bg2pd,
  input  logic [15:0]       bg3pb,
  input  logic [15:0]       bg3pd,
  output bg_pkg::bg_coord_t coord,
  output logic [15:0]       bg_screen_addr
);
  import bg_pkg::*;

  logic [1:0][27:0] cur_x, cur_y;    // running point, [0] = bg2, [1] = bg3
  logic [1:0][27:0] line_x, line_y;  // point at col 0 of the current line
  logic [1:0][15:0] dmx, dmy;
  logic             frame_start;
  logic             idx;
  logic [27:0]      pt_x, pt_y;
  logic [9:0]       tx, ty, xs, ys;
  logic             outside;
  logic [4:0]       hstep, vstep;
  bg_coord_t        next;
  logic [9:0]       hmax_q;
  logic [13:0]      tile_idx;
  logic [1:0]       blocks;

  function automatic logic [27:0] sext(input logic [15:0] v);
    return {{12{v[15]}}, v};
  endfunction

  assign dmx = {bg3pb, bg2pb};
  assign dmy = {bg3pd, bg2pd};
  assign idx = slot.bgno[0];

  // line start comes from the reference registers on the first line of a frame
  always_comb begin
    if (slot.col == 9'd0) begin
      pt_x = frame_start ? layer.ref_x : line_x[idx];
      pt_y = frame_start ? layer.ref_y : line_y[idx];
    end else begin
      pt_x = cur_x[idx];
      pt_y = cur_y[idx];
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      frame_start <= 1'b1;
    end else if (start_row) begin
      frame_start <= new_frame;
    end
  end

  always_ff @(posedge clock) begin
    if (start_row) begin
      for (int i = 0; i < 2; i++) begin
        line_x[i] <= line_x[i] + sext(dmx[i]);  // dmx per line
        line_y[i] <= line_y[i] + sext(dmy[i]);
      end
    end
    if (slot.bgno[1]) begin
      cur_x[idx] <= pt_x + sext(layer.pa);
      cur_y[idx] <= pt_y + sext(layer.pc);
      if (slot.col == 9'd0) begin
        line_x[idx] <= pt_x;
        line_y[idx] <= pt_y;
      end
    end
  end

  always_comb begin
    tx      = ({1'b0, slot.col} + {1'b0, layer.hofs}) & layer.hmax;
    ty      = ({2'b0, slot.row} + {1'b0, layer.vofs}) & layer.vmax;
    outside = pt_x[27] || pt_y[27] ||
              (pt_x[26:8] > {9'd0, layer.hmax}) || (pt_y[26:8] > {9'd0, layer.vmax});
    xs      = layer.rotate ? (pt_x[17:8] & layer.hmax) : tx;
    ys      = layer.rotate ? (pt_y[17:8] & layer.vmax) : ty;

    hstep = {1'b0, mosaic_reg[3:0]} + 5'd1;
    vstep = {1'b0, mosaic_reg[7:4]} + 5'd1;
    if (layer.mosaic_en) begin
      xs = xs - (xs % {5'd0, hstep});
      ys = ys - (ys % {5'd0, vstep});
    end

    next.x           = xs;
    next.y           = ys;
    next.col         = slot.col;
    next.enabled     = layer.enabled;
    next.bg_priority = layer.bg_priority;
    next.bgno        = layer.bgno;
    next.rotate      = layer.rotate;
    next.palettemode = layer.palettemode;
    next.char_base   = layer.char_base;
    next.screen_base = layer.screen_base;
    next.transparent = layer.rotate && !layer.wrap && outside;
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      coord  <= '0;
      hmax_q <= '0;
    end else begin
      coord  <= next;
      hmax_q <= layer.hmax;
    end
  end

  // halfword address of the map entry
  always_comb begin
    tile_idx = coord.y[9:3] * ({1'b0, hmax_q[9:3]} + 8'd1) + {7'd0, coord.x[9:3]};
    blocks   = {1'b0, coord.x[8]};
    if (coord.y[8]) begin
      blocks = blocks + (hmax_q[8] ? 2'd2 : 2'd1);
    end
    if (coord.rotate) begin
      bg_screen_addr = {1'b0, coord.screen_base, 10'd0} + {3'd0, tile_idx[13:1]};
    end else begin
      bg_screen_addr = {1'b0, coord.screen_base, 10'd0} + {4'd0, blocks, 10'd0}
                     + {6'd0, coord.y[7:3], coord.x[7:3]};
    end
  end

endmodule

/* rtl/bg_reg_decoder.sv */
`timescale 1ns/1ps

module bg_reg_decoder (
  input  logic [3:0][15:0]  bgcnt,
  input  logic [3:0][15:0]  hofs,
  input  logic [3:0][15:0]  vofs,
  input  logic [27:0]       bg2x,
  input  logic [27:0]       bg3x,
  input  logic [27:0]       bg2y,
  input  logic [27:0]       bg3y,
  input  logic [15:0]       bg2pa,
  input  logic [15:0]       bg2pc,
  input  logic [15:0]       bg3pa,
  input  logic [15:0]       bg3pc,
  input  logic [15:0]       dispcnt,
  input  logic [15:0]       mosaic_reg,
  input  logic [1:0]        bgno,
  output bg_pkg::bg_layer_t layer
);
  import bg_pkg::*;

  logic [15:0] cnt;
  logic [2:0]  mode;
  logic        rotate;
  logic        mode_ok;

  assign cnt  = bgcnt[bgno];
  assign mode = dispcnt[2:0];

  always_comb begin
    rotate  = 1'b0;
    mode_ok = 1'b0;
    case (mode)
      BG_MODE_TEXT: begin
        mode_ok = 1'b1;
      end
      BG_MODE_MIXED: begin
        mode_ok = (bgno != 2'd3);
        rotate  = (bgno == 2'd2);
      end
      BG_MODE_AFFINE: begin
        mode_ok = bgno[1];
        rotate  = bgno[1];
      end
      default: begin
        mode_ok = 1'b0;  // bitmap modes not rendered here
      end
    endcase
  end

  always_comb begin
    layer             = '0;
    layer.enabled     = dispcnt[8 + bgno] && mode_ok;
    layer.bg_priority = cnt[1:0];
    layer.bgno        = bgno;
    layer.rotate      = rotate;
    layer.palettemode = cnt[7] || rotate;  // affine maps are always 8bpp
    layer.mosaic_en   = cnt[6] && (mosaic_reg[7:0] != 8'd0);
    layer.wrap        = cnt[13];
    layer.char_base   = cnt[3:2];
    layer.screen_base = cnt[12:8];
    layer.size        = cnt[15:14];
    layer.hofs        = hofs[bgno][8:0];
    layer.vofs        = vofs[bgno][8:0];
    layer.pa          = bgno[0] ? bg3pa : bg2pa;
    layer.pc          = bgno[0] ? bg3pc : bg2pc;
    layer.ref_x       = bgno[0] ? bg3x : bg2x;
    layer.ref_y       = bgno[0] ? bg3y : bg2y;

    if (rotate) begin
      // square maps, 128 to 1024 pixels
      case (cnt[15:14])
        2'd0:    layer.hmax = 10'd127;
        2'd1:    layer.hmax = 10'd255;
        2'd2:    layer.hmax = 10'd511;
        default: layer.hmax = 10'd1023;
      endcase
      layer.vmax = layer.hmax;
    end else begin
      layer.hmax = cnt[14] ? 10'd511 : 10'd255;
      layer.vmax = cnt[15] ? 10'd511 : 10'd255;
    end
  end

endmodule

/* rtl/bg_scan_counter.sv */
`timescale 1ns/1ps

module bg_scan_counter #(
  parameter int LINE_SLOTS    = 308,
  parameter int FRAME_LINES   = 228,
  parameter int VISIBLE_COLS  = 240,
  parameter int VISIBLE_LINES = 160
) (
  input  logic             clock,
  input  logic             rst_n,
  output bg_pkg::bg_slot_t slot,
  output logic             start_row,
  output logic             new_frame
);

  logic [10:0] col_bgno;  // {col, bgno}, layer in the low bits
  logic [7:0]  line;

  assign start_row = (col_bgno[10:2] == 9'(LINE_SLOTS - 1)) && (col_bgno[1:0] == 2'd3);
  assign new_frame = start_row && (line == 8'(FRAME_LINES - 1));

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      col_bgno <= '0;
    end else if (start_row) begin
      col_bgno <= '0;
    end else begin
      col_bgno <= col_bgno + 11'd1;
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      line <= '0;
    end else if (new_frame) begin
      line <= '0;
    end else if (start_row) begin
      line <= line + 8'd1;
    end
  end

  always_comb begin
    slot.col     = col_bgno[10:2];
    slot.bgno    = col_bgno[1:0];
    slot.row     = line;
    slot.visible = (col_bgno[10:2] < 9'(VISIBLE_COLS)) && (line < 8'(VISIBLE_LINES));
  end

endmodule

/* rtl/bg_pkg.sv */
package bg_pkg;

  // dispcnt[2:0] background modes
  localparam logic [2:0] BG_MODE_TEXT   = 3'd0;
  localparam logic [2:0] BG_MODE_MIXED  = 3'd1;  // bg0/bg1 text, bg2 affine
  localparam logic [2:0] BG_MODE_AFFINE = 3'd2;

  // decoded state of the layer in the current slot
  typedef struct packed {
    logic        enabled;
    logic [1:0]  bg_priority;
    logic [1:0]  bgno;
    logic        rotate;
    logic        palettemode;  // 1 = 256 colours
    logic        mosaic_en;
    logic        wrap;
    logic [1:0]  char_base;
    logic [4:0]  screen_base;
    logic [1:0]  size;
    logic [8:0]  hofs;
    logic [8:0]  vofs;
    logic [15:0] pa;
    logic [15:0] pc;
    logic [27:0] ref_x;        // 20.8 fixed point
    logic [27:0] ref_y;
    logic [9:0]  hmax;
    logic [9:0]  vmax;
  } bg_layer_t;

  typedef struct packed {
    logic [8:0] col;
    logic [1:0] bgno;
    logic [7:0] row;
    logic       visible;
  } bg_slot_t;

  typedef struct packed {
    logic [9:0] x;
    logic [9:0] y;
    logic [8:0] col;           // screen column, becomes hcount
    logic       enabled;
    logic [1:0] bg_priority;
    logic [1:0] bgno;
    logic       rotate;
    logic       palettemode;
    logic [1:0] char_base;
    logic [4:0] screen_base;
    logic       transparent;   // affine point off the map, no wrap
  } bg_coord_t;

  typedef struct packed {
    logic       used;
    logic [1:0] bg_priority;
    logic [1:0] bgno;
    logic       transparent;
    logic       palettemode;
    logic [7:0] color_index;
  } bg_pixel_t;

endpackage
